//--- hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] inst_t;  // one fetched word.
    typedef logic [15:0] cinst_t; // compressed half.

    // major opcodes, bits [6:0] of a 32-bit instruction.
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111,
        op_system = 7'b1110011
    } opcode_e;

    // low two bits, 2'b11 marks a full-width instruction.
    typedef enum logic [1:0] {
        c_q0  = 2'b00,
        c_q1  = 2'b01,
        c_q2  = 2'b10,
        c_q32 = 2'b11
    } c_quad_e;

    // funct3 [15:13] of the compressed jumps.
    typedef enum logic [2:0] {
        c_jal = 3'b001, // quadrant 1, rv32 only.
        c_jr  = 3'b100, // quadrant 2, also c.jalr.
        c_j   = 3'b101  // quadrant 1.
    } c_funct3_e;

endpackage

`default_nettype wire

//--- hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] addr_t; // byte address.

    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_wait_mem  = 2'd1,
        st_wait_jalr = 2'd2
    } fetch_state_e;

    // retire_pc value meaning advance by the head length.
    localparam addr_t retire_seq = 32'hffff_ffff;

endpackage

`default_nettype wire

//--- hw/next_pc_predict.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc_predict (
    input  wire rv_isa_pkg::inst_t word,
    input  wire fetch_pkg::addr_t  pc,
    output logic                   is32,
    output fetch_pkg::addr_t       next_pc,
    output logic                   stop
);
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    cinst_t    cw;
    opcode_e   op;
    c_quad_e   quad;
    c_funct3_e cf3;
    addr_t     j_imm;
    addr_t     cj_imm;
    addr_t     seq_pc;
    logic      c_jump;
    logic      c_indirect;

    assign cw   = word[15:0];
    assign op   = opcode_e'(word[6:0]);
    assign quad = c_quad_e'(word[1:0]);
    assign cf3  = c_funct3_e'(cw[15:13]);

    assign is32   = (quad == c_q32);
    assign seq_pc = is32 ? pc + 32'd4 : pc + 32'd2;

    // j-type, imm[20|10:1|11|19:12].
    assign j_imm = {
        {11{word[31]}},
        word[31],
        word[19:12],
        word[20],
        word[30:21],
        1'b0
    };

    // cj-type, imm[11|4|9:8|10|6|7|3:1|5].
    assign cj_imm = {
        {20{cw[12]}},
        cw[12],
        cw[8],
        cw[10:9],
        cw[6],
        cw[7],
        cw[2],
        cw[11],
        cw[5:3],
        1'b0
    };

    assign c_jump = (quad == c_q1) && ((cf3 == c_j) || (cf3 == c_jal));

    // c.jr and c.jalr need rs1 set and rs2 clear.
    assign c_indirect = (quad == c_q2) && (cf3 == c_jr) &&
                        (cw[6:2] == 5'd0) && (cw[11:7] != 5'd0);

    always_comb begin
        next_pc = seq_pc;
        stop    = 1'b0;
        if (is32) begin
            case (op)
                op_jal: begin
                    next_pc = pc + j_imm;
                end
                op_jalr: begin
                    stop = 1'b1; // target comes from the core.
                end
                default: begin
                    next_pc = seq_pc; // branches predicted not taken.
                end
            endcase
        end else if (c_jump) begin
            next_pc = pc + cj_imm;
        end else if (c_indirect) begin
            stop = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl #(
    parameter fetch_pkg::addr_t start_pc = 32'h0000_0000
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire rv_isa_pkg::inst_t mem_data,
    input  wire                    mem_valid,
    input  wire                    branch_taken,
    input  wire fetch_pkg::addr_t  branch_pc,
    input  wire                    jalr_valid,
    input  wire fetch_pkg::addr_t  jalr_addr,
    input  wire                    lsb_full,
    input  wire                    iq_full,
    input  wire                    len_full,
    output logic                   mem_req,
    output fetch_pkg::addr_t       mem_addr,
    output logic                   inst_valid,
    output rv_isa_pkg::inst_t      inst,
    output fetch_pkg::addr_t       inst_pc,
    output logic                   inst_is32,
    output logic                   flush
);
    import fetch_pkg::*;

    fetch_state_e state;
    addr_t        pred_pc;
    logic         stale;
    logic         issue;
    logic         deliver;
    logic         keep_wait;
    logic         pred_is32;
    logic         pred_stop;
    addr_t        pred_next;

    assign issue = (state == st_idle) && !branch_taken &&
                   !lsb_full && !iq_full && !len_full;

    assign deliver = (state == st_wait_mem) && mem_valid && !stale && !branch_taken;

    // redirect while a response is still out.
    assign keep_wait = (state == st_wait_mem) && !mem_valid;

    next_pc_predict u_predict (
        .word    (mem_data),
        .pc      (pred_pc),
        .is32    (pred_is32),
        .next_pc (pred_next),
        .stop    (pred_stop)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            pred_pc    <= start_pc;
            stale      <= 1'b0;
            mem_req    <= 1'b0;
            inst_valid <= 1'b0;
            flush      <= 1'b0;
        end else begin
            mem_req    <= issue;
            inst_valid <= deliver;
            flush      <= branch_taken;
            if (branch_taken) begin
                pred_pc <= branch_pc; // wins over jalr_valid.
                stale   <= keep_wait;
                state   <= keep_wait ? st_wait_mem : st_idle;
            end else begin
                case (state)
                    st_idle: begin
                        if (issue) begin
                            state <= st_wait_mem;
                        end
                    end
                    st_wait_mem: begin
                        if (mem_valid) begin
                            stale <= 1'b0;
                            if (stale) begin
                                state <= st_idle; // old path, dropped.
                            end else begin
                                pred_pc <= pred_next;
                                state   <= pred_stop ? st_wait_jalr : st_idle;
                            end
                        end
                    end
                    st_wait_jalr: begin
                        if (jalr_valid) begin
                            pred_pc <= jalr_addr;
                            state   <= st_idle;
                        end
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            mem_addr <= pred_pc;
        end
        if (deliver) begin
            inst      <= mem_data;
            inst_pc   <= pred_pc; // still the request address.
            inst_is32 <= pred_is32;
        end
    end

endmodule

`default_nettype wire

//--- hw/commit_pc_track.sv
`timescale 1ns/1ps
`default_nettype none

module commit_pc_track #(
    parameter fetch_pkg::addr_t start_pc  = 32'h0000_0000,
    parameter int               len_depth = 32
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   push,
    input  wire                   push_is32,
    input  wire                   retire,
    input  wire fetch_pkg::addr_t retire_pc,
    input  wire fetch_pkg::addr_t flush_pc,
    input  wire                   flush,
    output fetch_pkg::addr_t      commit_pc,
    output logic                  len_full
);
    import fetch_pkg::*;

    localparam int ptr_w = $clog2(len_depth);

    // one slot stays free for the word still in flight.
    localparam logic [ptr_w:0] full_lvl = (ptr_w + 1)'(len_depth - 1);

    logic             len_q [len_depth]; // 1 for 32-bit.
    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [ptr_w:0]   count;
    logic             pop;
    addr_t            head_len;

    assign pop      = retire && (count != '0);
    assign head_len = len_q[head] ? 32'd4 : 32'd2;
    assign len_full = (count >= full_lvl);

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            commit_pc <= start_pc;
        end else if (flush) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            commit_pc <= flush_pc;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (retire) begin
                if (retire_pc == retire_seq) begin
                    commit_pc <= commit_pc + head_len;
                end else begin
                    commit_pc <= retire_pc; // taken control flow.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            len_q[tail] <= push_is32;
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter fetch_pkg::addr_t start_pc  = 32'h0000_0000,
    parameter int               len_depth = 32
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire rv_isa_pkg::inst_t mem_data,
    input  wire                    mem_valid,
    input  wire                    branch_taken,
    input  wire fetch_pkg::addr_t  branch_pc,
    input  wire                    jalr_valid,
    input  wire fetch_pkg::addr_t  jalr_addr,
    input  wire                    retire,
    input  wire fetch_pkg::addr_t  retire_pc,
    input  wire                    lsb_full,
    input  wire                    iq_full,
    output wire                    mem_req,
    output wire fetch_pkg::addr_t  mem_addr,
    output wire                    inst_valid,
    output wire rv_isa_pkg::inst_t inst,
    output wire fetch_pkg::addr_t  inst_pc,
    output wire fetch_pkg::addr_t  commit_pc,
    output wire                    flush
);

    logic inst_is32;
    logic len_full;

    fetch_ctrl #(
        .start_pc (start_pc)
    ) u_fetch_ctrl (
        .clk          (clk),
        .rst          (rst),
        .mem_data     (mem_data),
        .mem_valid    (mem_valid),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc),
        .jalr_valid   (jalr_valid),
        .jalr_addr    (jalr_addr),
        .lsb_full     (lsb_full),
        .iq_full      (iq_full),
        .len_full     (len_full),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_pc      (inst_pc),
        .inst_is32    (inst_is32),
        .flush        (flush)
    );

    // redirect goes straight in so commit_pc settles with flush.
    commit_pc_track #(
        .start_pc  (start_pc),
        .len_depth (len_depth)
    ) u_commit_pc_track (
        .clk       (clk),
        .rst       (rst),
        .push      (inst_valid),
        .push_is32 (inst_is32),
        .retire    (retire),
        .retire_pc (retire_pc),
        .flush_pc  (branch_pc),
        .flush     (branch_taken),
        .commit_pc (commit_pc),
        .len_full  (len_full)
    );

endmodule

`default_nettype wire

//--- verif/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    localparam int max_words = 160;

    logic  clk;
    logic  rst;
    inst_t mem_data;
    logic  mem_valid;
    logic  branch_taken;
    addr_t branch_pc;
    logic  jalr_valid;
    addr_t jalr_addr;
    logic  retire;
    addr_t retire_pc;
    logic  lsb_full;
    logic  iq_full;
    logic  mem_req;
    addr_t mem_addr;
    logic  inst_valid;
    inst_t inst;
    addr_t inst_pc;
    addr_t commit_pc;
    logic  flush;

    logic [31:0] case_words [max_words]; // five words per case.
    inst_t       image [addr_t];
    bit          slow_addr [addr_t];
    addr_t       req_q [$];
    inst_t       inst_q [$];
    addr_t       pc_q [$];
    int          n_cases;
    int          errors;
    int          tests;
    int          failed;
    int          flush_cnt;
    int          resp_cnt;
    bit          loaded;

    fetch_top #(
        .start_pc  (32'h0000_0000),
        .len_depth (32)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .mem_data     (mem_data),
        .mem_valid    (mem_valid),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc),
        .jalr_valid   (jalr_valid),
        .jalr_addr    (jalr_addr),
        .retire       (retire),
        .retire_pc    (retire_pc),
        .lsb_full     (lsb_full),
        .iq_full      (iq_full),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_pc      (inst_pc),
        .commit_pc    (commit_pc),
        .flush        (flush)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic wait_request(output addr_t a);
        while (req_q.size() == 0) begin
            @(posedge clk);
        end
        a = req_q.pop_front();
    endtask

    task automatic wait_delivery(output inst_t w, output addr_t p);
        while (inst_q.size() == 0) begin
            @(posedge clk);
        end
        w = inst_q.pop_front();
        p = pc_q.pop_front();
    endtask

    task automatic close_test(input int id, input int err_base);
        tests++;
        if (errors > err_base) begin
            failed++;
            $display("test %0d %s: failed, %0d errors", id, test_name(id), errors - err_base);
        end else begin
            $display("test %0d %s: ok", id, test_name(id));
        end
    endtask

    function automatic string test_name(input int id);
        case (id)
            1: return "sequential";
            2: return "compressed";
            3: return "jumps";
            4: return "jalr";
            5: return "branch";
            6: return "retire";
            default: return "unknown";
        endcase
    endfunction

    // next fetch address from the rv32ic encoding.
    function automatic addr_t predict_next(input addr_t pc, input inst_t w);
        logic [20:0] jimm;
        logic [11:0] cjimm;
        jimm  = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        cjimm = {w[12], w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
        if (w[1:0] == 2'b11) begin
            if (w[6:0] == op_jal) begin
                return pc + {{11{jimm[20]}}, jimm};
            end
            return pc + 32'd4;
        end
        if (w[1:0] == 2'b01 && (w[15:13] == c_j || w[15:13] == c_jal)) begin
            return pc + {{20{cjimm[11]}}, cjimm};
        end
        return pc + 32'd2;
    endfunction

    always @(negedge clk) begin
        if (!rst) begin
            if (mem_req) begin
                req_q.push_back(mem_addr);
            end
            if (inst_valid) begin
                inst_q.push_back(inst);
                pc_q.push_back(inst_pc);
            end
            if (flush) begin
                flush_cnt++;
            end
        end
    end

    initial begin : mem_model
        addr_t addr;
        int    lat;
        mem_valid <= 1'b0;
        mem_data  <= '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req) begin
                addr = mem_addr;
                // branch case keeps its response out long.
                lat = slow_addr.exists(addr) ? 4 : $urandom_range(4, 1);
                repeat (lat) @(posedge clk);
                mem_valid <= 1'b1;
                mem_data  <= image.exists(addr) ? image[addr] : 32'h0000_0013;
                resp_cnt++;
                @(posedge clk);
                mem_valid <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        while (!loaded) begin
            @(posedge clk);
        end
        repeat (n_cases * 200 + 20) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", n_cases * 200 + 20);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main
        int          i;
        int          t;
        int          cur_test;
        int          test_err;
        int          flush_before;
        int          resp_before;
        logic [31:0] kind;
        addr_t       a;
        logic [31:0] b;
        addr_t       c;
        addr_t       got_addr;
        inst_t       got_inst;
        addr_t       exp_next;
        bit          next_known;
        void'($urandom(32'h219f1227));
        rst          <= 1'b1;
        branch_taken <= 1'b0;
        branch_pc    <= '0;
        jalr_valid   <= 1'b0;
        jalr_addr    <= '0;
        retire       <= 1'b0;
        retire_pc    <= '0;
        lsb_full     <= 1'b0;
        iq_full      <= 1'b0;
        $readmemh("verif/fetch_cases.txt", case_words);
        n_cases = 0;
        while (n_cases < max_words / 5 && case_words[5 * n_cases] != 0) begin
            n_cases++;
        end
        for (i = 0; i < n_cases; i++) begin
            kind = case_words[5 * i + 1];
            if (kind != 4) begin
                image[case_words[5 * i + 2]] = case_words[5 * i + 3];
            end
            if (kind == 3) begin
                slow_addr[case_words[5 * i + 2]] = 1'b1;
            end
        end
        if (n_cases == 0) begin
            note_failure("case file is missing or holds no cases");
        end
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        cur_test   = 0;
        test_err   = 0;
        next_known = 1'b0;
        for (i = 0; i < n_cases; i++) begin
            t    = case_words[5 * i];
            kind = case_words[5 * i + 1];
            a    = case_words[5 * i + 2];
            b    = case_words[5 * i + 3];
            c    = case_words[5 * i + 4];
            if (t != cur_test) begin
                if (cur_test != 0) begin
                    close_test(cur_test, test_err);
                end
                cur_test = t;
                test_err = errors;
            end
            if (kind == 4) begin
                @(posedge clk);
                retire    <= 1'b1;
                retire_pc <= a;
                @(posedge clk);
                retire <= 1'b0;
                @(negedge clk);
                check_addr("commit_pc", commit_pc, b);
            end else begin
                wait_request(got_addr);
                check_addr("mem_addr", got_addr, a);
                if (next_known) begin
                    check_addr("mem_addr", got_addr, exp_next); // decoded from last word.
                end
                next_known = 1'b0;
                if (kind == 3) begin
                    flush_before = flush_cnt;
                    resp_before  = resp_cnt;
                    @(posedge clk);
                    branch_taken <= 1'b1;
                    branch_pc    <= c;
                    @(posedge clk);
                    branch_taken <= 1'b0;
                    while (resp_cnt == resp_before) begin
                        @(posedge clk);
                    end
                    repeat (2) @(posedge clk);
                    @(negedge clk);
                    if (inst_q.size() != 0) begin
                        note_failure("stale response was delivered after the redirect");
                    end
                    if (flush_cnt != flush_before + 1) begin
                        note_failure("flush did not pulse exactly once");
                    end
                    check_addr("commit_pc", commit_pc, c);
                end else begin
                    wait_delivery(got_inst, got_addr);
                    check_inst("inst", got_inst, b);
                    check_addr("inst_pc", got_addr, a);
                    if (kind == 1) begin
                        exp_next   = predict_next(a, b);
                        next_known = 1'b1;
                    end
                    if (kind == 2) begin
                        repeat (10) @(posedge clk);
                        if (req_q.size() != 0) begin
                            note_failure("mem_req issued while waiting for jalr_valid");
                        end
                        jalr_valid <= 1'b1;
                        jalr_addr  <= c;
                        iq_full    <= 1'b1;
                        @(posedge clk);
                        jalr_valid <= 1'b0;
                        repeat (10) @(posedge clk);
                        if (req_q.size() != 0) begin
                            note_failure("mem_req issued while iq_full was high");
                        end
                        iq_full <= 1'b0;
                    end
                end
            end
        end
        if (cur_test != 0) begin
            close_test(cur_test, test_err);
        end
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/fetch_cases.txt
// test kind addr word arg, one fetch or retire step per line
// kind 1 fetch (arg next pc), 2 jalr (arg target), 3 branch (arg branch_pc), 5 final jalr
// kind 4 retire (addr is retire_pc, word is expected commit_pc), all zeros ends the list
00000001 00000001 00000000 00100093 00000004
00000001 00000001 00000004 00208113 00000008
00000001 00000001 00000008 002081b3 0000000c
00000002 00000001 0000000c 00000505 0000000e
00000002 00000001 0000000e 00000001 00000010
00000003 00000001 00000010 0100006f 00000020
00000003 00000001 00000020 0000a021 00000028
00000004 00000002 00000028 00008067 00000040
00000005 00000003 00000040 00000013 00000080
00000006 00000001 00000080 00000001 00000082
00000006 00000001 00000082 00100093 00000086
00000006 00000001 00000086 00000505 00000088
00000006 00000005 00000088 00008067 00000000
00000006 00000004 ffffffff 00000082 00000000
00000006 00000004 ffffffff 00000086 00000000
00000006 00000004 ffffffff 00000088 00000000
00000006 00000004 00000200 00000200 00000000
00000000 00000000 00000000 00000000 00000000

//--- vlog.f
hw/rv_isa_pkg.sv
hw/fetch_pkg.sv
hw/next_pc_predict.sv
hw/fetch_ctrl.sv
hw/commit_pc_track.sv
hw/fetch_top.sv
verif/fetch_tb.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench.

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module fetch_tb -f vlog.f \
		--Mdir obj_dir -o fetch_sim

run: compile
	./obj_dir/fetch_sim | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
